//--- source/corr_pkg.sv
package corr_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int N_LANES    = 4;                  // Templates, one lane each
    localparam int LANE_IDX_W = $clog2(N_LANES);
    localparam int VEC_LEN    = 8;                  // Samples per vector
    localparam int POS_W      = $clog2(VEC_LEN);
    localparam int SAMPLE_W   = 12;
    localparam int COEF_W     = 12;
    localparam int DOT_W      = 27;                 // 8 * 4095 * 4095 still fits
    localparam int NORM_W     = 27;
    localparam int CORR_W     = 10;

    localparam logic [CORR_W-1:0]     CORR_MAX  = 10'd1023;
    localparam logic [POS_W-1:0]      LAST_POS  = POS_W'(VEC_LEN - 1);
    localparam logic [LANE_IDX_W-1:0] LAST_LANE = LANE_IDX_W'(N_LANES - 1);

    // Latencies
    localparam int DIV_LAT    = DOT_W;              // One quotient bit per stage
    localparam int RESULT_LAT = DIV_LAT + N_LANES + 3;

    // Elaboration-time tables
    localparam TEMPLATE_FILE = "templates.hex";     // One row per sample position
    localparam NORM_FILE     = "norms.hex";         // One squared norm per lane

    //////////////////////////////////////////////////
    // Types

    // Coefficient row, lane 0 in the low bits
    typedef logic [N_LANES-1:0][COEF_W-1:0] coef_row_t;

    typedef struct packed {
        logic                valid;
        logic                first;                 // Sample position 0
        logic                last;                  // Sample position VEC_LEN-1
        logic [SAMPLE_W-1:0] sample;
        logic [COEF_W-1:0]   coef;
    } mac_step_t;

    typedef struct packed {
        logic             valid;
        logic [DOT_W-1:0] dot;
    } dot_result_t;

    typedef struct packed {
        logic              valid;
        logic [DOT_W-1:0]  dividend;
        logic [NORM_W-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic             valid;
        logic [DOT_W-1:0] quotient;
    } div_resp_t;

    typedef struct packed {
        logic [N_LANES-1:0][CORR_W-1:0] correlations;   // Indexed by lane
        logic [LANE_IDX_W-1:0]          best_index;
        logic [CORR_W-1:0]              best_score;
    } correlation_result_t;

endpackage

//--- source/template_sequencer.sv
`timescale 1ns/100ps

module template_sequencer
    import corr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  logic [SAMPLE_W-1:0] sample,
    output mac_step_t           steps [N_LANES]
);

    // Coefficients of all templates, addressed by sample position
    coef_row_t coef_rom [VEC_LEN];

    initial $readmemh(TEMPLATE_FILE, coef_rom);

    logic [POS_W-1:0]    pos_q;         // Next sample position
    logic                valid_q;
    logic                first_q;
    logic                last_q;
    coef_row_t           coef_q;        // Registered ROM read
    logic [SAMPLE_W-1:0] sample_q;

    //////////////////////////////////////////////////
    // Stage 1: accept sample, read coefficient row

    always_ff @(posedge clk) begin
        if (reset) begin
            pos_q   <= '0;              // Partial vector dropped
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= sample_valid;
            if (sample_valid) begin
                first_q <= (pos_q == '0);
                last_q  <= (pos_q == LAST_POS);
                pos_q   <= (pos_q == LAST_POS) ? '0 : pos_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            coef_q   <= coef_rom[pos_q];
            sample_q <= sample;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2: one step per lane, same sample to all

    always_ff @(posedge clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            if (reset) begin
                steps[i] <= '0;
            end else begin
                steps[i] <= '{valid:  valid_q,
                              first:  first_q,
                              last:   last_q,
                              sample: sample_q,
                              coef:   coef_q[i]};
            end
        end
    end

endmodule

//--- source/dot_product_lane.sv
`timescale 1ns/100ps

module dot_product_lane
    import corr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  mac_step_t   step,
    output dot_result_t dot_out
);

    logic [DOT_W-1:0] product;
    logic [DOT_W-1:0] sum;
    logic [DOT_W-1:0] acc_q;        // Running sum of the current vector
    logic [DOT_W-1:0] dot_q;
    logic             dot_valid_q;

    // Widen before multiply so the 24-bit product is kept
    assign product = DOT_W'(step.sample) * DOT_W'(step.coef);

    // First step of a vector restarts the sum
    assign sum = step.first ? product : acc_q + product;

    always_ff @(posedge clk) begin
        if (step.valid) begin
            acc_q <= sum;
        end
        if (step.valid && step.last) begin
            dot_q <= sum;           // Finished dot product
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dot_valid_q <= 1'b0;
        end else begin
            dot_valid_q <= step.valid && step.last;   // One-cycle strobe
        end
    end

    assign dot_out = '{valid: dot_valid_q, dot: dot_q};

endmodule

//--- source/pipelined_divider.sv
`timescale 1ns/100ps

module pipelined_divider
    import corr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  div_req_t  req,
    output div_resp_t resp
);

    // State carried from one restoring step to the next
    typedef struct packed {
        logic [NORM_W-1:0] rem;         // Partial remainder
        logic [DOT_W-1:0]  work;        // Dividend out at the top, quotient in at the bottom
        logic [NORM_W-1:0] divisor;
    } stage_t;

    // One restoring step, quotient bit from the MSB down
    function automatic stage_t div_step(input stage_t s);
        logic [NORM_W:0] shifted;
        logic [NORM_W:0] diff;
        logic            fits;
        stage_t          n;
        shifted   = {s.rem, s.work[DOT_W-1]};
        diff      = shifted - {1'b0, s.divisor};
        fits      = (shifted >= {1'b0, s.divisor});   // Always true for a zero divisor
        n.rem     = fits ? diff[NORM_W-1:0] : shifted[NORM_W-1:0];
        n.work    = {s.work[DOT_W-2:0], fits};
        n.divisor = s.divisor;
        return n;
    endfunction

    stage_t             stage_in;
    stage_t             stage_q [DIV_LAT];
    logic [DIV_LAT-1:0] valid_q;

    assign stage_in = '{rem: '0, work: req.dividend, divisor: req.divisor};

    //////////////////////////////////////////////////
    // Valid bits travel alongside the datapath

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[DIV_LAT-2:0], req.valid};
        end
    end

    //////////////////////////////////////////////////
    // DIV_LAT registered steps, a new division every cycle

    always_ff @(posedge clk) begin
        stage_q[0] <= div_step(stage_in);
        for (int i = 1; i < DIV_LAT; i++) begin
            stage_q[i] <= div_step(stage_q[i-1]);
        end
    end

    // Last stage holds the full quotient, remainder is dropped
    assign resp = '{valid: valid_q[DIV_LAT-1], quotient: stage_q[DIV_LAT-1].work};

endmodule

//--- source/correlation_normalizer.sv
`timescale 1ns/100ps

module correlation_normalizer
    import corr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  dot_result_t         dots [N_LANES],
    output div_req_t            div_req,
    input  div_resp_t           div_resp,
    output logic                result_valid,
    output correlation_result_t result
);

    // Squared norm of each template
    logic [NORM_W-1:0] norm_rom [N_LANES];

    initial $readmemh(NORM_FILE, norm_rom);

    logic [DOT_W-1:0]               dot_bank [N_LANES];
    logic                           sending_q;
    logic [LANE_IDX_W-1:0]          send_idx_q;
    logic [LANE_IDX_W-1:0]          issue_idx;
    logic [DOT_W-1:0]               issue_dot;
    logic                           req_valid_q;
    logic [DOT_W-1:0]               req_dividend_q;
    logic [NORM_W-1:0]              req_divisor_q;
    logic [LANE_IDX_W-1:0]          recv_idx_q;
    logic [CORR_W-1:0]              sat;
    logic                           take_new;
    logic [CORR_W-1:0]              next_score;
    logic [LANE_IDX_W-1:0]          next_idx;
    logic [CORR_W-1:0]              best_score_q;
    logic [LANE_IDX_W-1:0]          best_idx_q;
    logic [N_LANES-1:0][CORR_W-1:0] corr_q;
    logic [N_LANES-1:0][CORR_W-1:0] corr_next;

    //////////////////////////////////////////////////
    // Issue side

    // Lane 0 goes straight from the input, the rest from the bank
    assign issue_idx = dots[0].valid ? '0 : send_idx_q;
    assign issue_dot = dots[0].valid ? dots[0].dot : dot_bank[send_idx_q];

    always_ff @(posedge clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            if (dots[i].valid) begin
                dot_bank[i] <= dots[i].dot;
            end
        end
        req_dividend_q <= issue_dot;
        req_divisor_q  <= norm_rom[issue_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sending_q   <= 1'b0;
            send_idx_q  <= '0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= dots[0].valid || sending_q;
            if (dots[0].valid) begin    // Common completion strobe
                sending_q  <= 1'b1;
                send_idx_q <= LANE_IDX_W'(1);
            end else if (sending_q) begin
                if (send_idx_q == LAST_LANE) begin
                    sending_q <= 1'b0;
                end
                send_idx_q <= (send_idx_q == LAST_LANE) ? '0 : send_idx_q + 1'b1;
            end
        end
    end

    assign div_req = '{valid: req_valid_q, dividend: req_dividend_q, divisor: req_divisor_q};

    //////////////////////////////////////////////////
    // Receive side, quotients return in issue order

    assign sat = (div_resp.quotient > DOT_W'(CORR_MAX)) ? CORR_MAX
                                                        : div_resp.quotient[CORR_W-1:0];

    // Strictly greater only, so a tie keeps the lower lane
    assign take_new   = (recv_idx_q == '0) || (sat > best_score_q);
    assign next_score = take_new ? sat : best_score_q;
    assign next_idx   = take_new ? recv_idx_q : best_idx_q;

    always_comb begin
        corr_next             = corr_q;
        corr_next[recv_idx_q] = sat;
    end

    always_ff @(posedge clk) begin
        if (div_resp.valid) begin
            corr_q       <= corr_next;
            best_score_q <= next_score;
            best_idx_q   <= next_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            recv_idx_q   <= '0;
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= div_resp.valid && (recv_idx_q == LAST_LANE);
            if (div_resp.valid) begin
                recv_idx_q <= (recv_idx_q == LAST_LANE) ? '0 : recv_idx_q + 1'b1;
                if (recv_idx_q == LAST_LANE) begin
                    result <= '{correlations: corr_next,    // Held until next vector
                                best_index:   next_idx,
                                best_score:   next_score};
                end
            end
        end
    end

endmodule

//--- source/template_correlator.sv
`timescale 1ns/100ps

module template_correlator
    import corr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  logic [SAMPLE_W-1:0] sample,
    output logic                result_valid,
    output correlation_result_t result
);

    mac_step_t   steps [N_LANES];
    dot_result_t dots [N_LANES];
    div_req_t    div_req;
    div_resp_t   div_resp;

    // Sample counter and coefficient ROM
    template_sequencer sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .steps        (steps)
    );

    //////////////////////////////////////////////////
    // One MAC lane per template

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        dot_product_lane lane_i (
            .clk     (clk),
            .reset   (reset),
            .step    (steps[g]),
            .dot_out (dots[g])
        );
    end

    correlation_normalizer normalizer_i (
        .clk          (clk),
        .reset        (reset),
        .dots         (dots),
        .div_req      (div_req),
        .div_resp     (div_resp),
        .result_valid (result_valid),
        .result       (result)
    );

    pipelined_divider divider_i (
        .clk   (clk),
        .reset (reset),
        .req   (div_req),
        .resp  (div_resp)       // DIV_LAT cycles behind req
    );

endmodule

//--- testbench/correlator_asserts.sv
`timescale 1ns/100ps

module correlator_asserts
    import corr_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input dot_result_t         dots [N_LANES],
    input logic                sending,
    input div_req_t            div_req,
    input logic                result_valid,
    input correlation_result_t result
);

    logic [N_LANES-1:0] dot_valid;    // One bit per lane

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            dot_valid[i] = dots[i].valid;
        end
    end

    //////////////////////////////////////////////////
    // Reset and issue window

    reset_clears_valids: assert property (
        @(posedge clk) reset |=> !result_valid && !div_req.valid
    ) else $error("result_valid or div_req.valid high in the cycle after reset");

    // Next vector's dots must not land on a bank still being drained
    no_dots_while_sending: assert property (
        @(posedge clk) disable iff (reset) sending |-> dot_valid == '0
    ) else $error("Dot result arrived while the normalizer was still issuing");

    //////////////////////////////////////////////////
    // Result invariants

    best_score_consistent: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |-> result.best_score == result.correlations[result.best_index]
    ) else $error("best_score differs from the correlation at best_index");

endmodule

//--- testbench/tb_template_correlator.sv
`timescale 1ns/100ps

module tb_template_correlator
    import corr_pkg::*;
();

    logic                clk = 1'b0;
    logic                reset;
    logic                sample_valid;
    logic [SAMPLE_W-1:0] sample;
    logic                result_valid;
    correlation_result_t result;

    coef_row_t           tmpl_rows [VEC_LEN];   // Reference copy of the template table
    logic [NORM_W-1:0]   norms [N_LANES];
    logic [SAMPLE_W-1:0] cur_vec [VEC_LEN];
    correlation_result_t exp_q [$];
    int                  due_q [$];
    int                  cycle = 0;             // Rising edges seen so far
    int                  last_edge;
    int                  errors = 0;
    int                  checked = 0;

    template_correlator dut_i (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .result_valid (result_valid),
        .result       (result)
    );

    bind correlation_normalizer correlator_asserts asserts_i (
        .clk          (clk),
        .reset        (reset),
        .dots         (dots),
        .sending      (sending_q),
        .div_req      (div_req),
        .result_valid (result_valid),
        .result       (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////
    // Reference model

    // Floor of dot over norm, saturated, lowest index wins a tie
    function automatic correlation_result_t expected_result();
        correlation_result_t r;
        longint unsigned     dot;
        longint unsigned     q;
        r = '0;
        for (int k = 0; k < N_LANES; k++) begin
            dot = 0;
            for (int p = 0; p < VEC_LEN; p++) begin
                dot += 64'(cur_vec[p]) * 64'(tmpl_rows[p][k]);
            end
            q = (norms[k] == '0) ? '1 : dot / 64'(norms[k]);
            r.correlations[k] = (q > 64'(CORR_MAX)) ? CORR_MAX : q[CORR_W-1:0];
            if (k == 0 || r.correlations[k] > r.best_score) begin
                r.best_index = LANE_IDX_W'(k);
                r.best_score = r.correlations[k];
            end
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus

    task automatic apply_reset(input int cycles);
        reset        = 1'b1;
        sample_valid = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        reset = 1'b0;
    endtask

    // Drives cur_vec[0..count-1], random idle gaps up to max_gap
    task automatic send_samples(input int count, input int max_gap);
        int gap;
        for (int p = 0; p < count; p++) begin
            sample_valid = 1'b1;
            sample       = cur_vec[p];
            @(posedge clk);
            #1;
            last_edge    = cycle;               // Edge that took this sample
            sample_valid = 1'b0;
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic send_vector(input int max_gap);
        correlation_result_t r;
        r = expected_result();
        send_samples(VEC_LEN, max_gap);
        exp_q.push_back(r);
        due_q.push_back(last_edge + RESULT_LAT);
    endtask

    task automatic random_vector();
        for (int p = 0; p < VEC_LEN; p++) begin
            cur_vec[p] = SAMPLE_W'($urandom_range(2**SAMPLE_W - 1, 0));
        end
    endtask

    task automatic fill_vector(input logic [SAMPLE_W-1:0] value);
        for (int p = 0; p < VEC_LEN; p++) begin
            cur_vec[p] = value;
        end
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Timeout with %0d results still outstanding", exp_q.size());
        end
    endtask

    //////////////////////////////////////////////////
    // Result checks, sampled mid-cycle

    always @(negedge clk) begin
        correlation_result_t exp_r;
        int                  exp_due;
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result_valid at cycle %0d with no vector outstanding", cycle);
            end else begin
                exp_r   = exp_q.pop_front();
                exp_due = due_q.pop_front();
                checked++;
                assert (cycle == exp_due) else begin
                    errors++;
                    $display("result_valid at cycle %0d, expected at cycle %0d", cycle, exp_due);
                end
                for (int k = 0; k < N_LANES; k++) begin
                    assert (result.correlations[k] == exp_r.correlations[k]) else begin
                        errors++;
                        $display("MISMATCH result.correlations[%0d] expected %h got %h",
                                 k, exp_r.correlations[k], result.correlations[k]);
                    end
                end
                assert (result.best_index == exp_r.best_index) else begin
                    errors++;
                    $display("MISMATCH result.best_index expected %h got %h",
                             exp_r.best_index, result.best_index);
                end
                assert (result.best_score == exp_r.best_score) else begin
                    errors++;
                    $display("MISMATCH result.best_score expected %h got %h",
                             exp_r.best_score, result.best_score);
                end
            end
        end
        if (due_q.size() > 0 && cycle > due_q[0]) begin
            errors++;
            $display("No result by cycle %0d for a vector due then", due_q[0]);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample       = '0;
        void'($urandom(99595));
        $readmemh(TEMPLATE_FILE, tmpl_rows);
        $readmemh(NORM_FILE, norms);
        apply_reset(3);

        for (int v = 0; v < 20; v++) begin     // Random data, random gaps
            random_vector();
            send_vector(3);
        end
        wait_drained(RESULT_LAT + 20);

        fill_vector('0);                        // All ties, index 0 expected
        send_vector(1);
        for (int k = 0; k < N_LANES; k++) begin
            for (int p = 0; p < VEC_LEN; p++) begin
                cur_vec[p] = SAMPLE_W'(tmpl_rows[p][k]);
            end
            send_vector(2);
        end
        fill_vector('1);                        // Full scale saturates
        send_vector(0);
        wait_drained(RESULT_LAT + 20);

        for (int v = 0; v < 10; v++) begin     // Several vectors in the divider
            random_vector();
            send_vector(0);
        end
        wait_drained(RESULT_LAT + 20);

        // Partial vector dropped by reset
        random_vector();
        send_samples(4, 0);
        apply_reset(3);
        random_vector();
        send_vector(0);
        wait_drained(RESULT_LAT + 20);

        $display("Results checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- templates.hex
// One row per sample position: lane3 lane2 lane1 lane0, 12 bits each
001002008001
001003008002
002002008003
001003008004
001002008005
002003008006
001002008007
001003008008

//--- norms.hex
// Squared norm of each template, lane 0 first
00000cc
0000200
0000034
000000e

//--- flist.f
source/corr_pkg.sv
source/template_sequencer.sv
source/dot_product_lane.sv
source/pipelined_divider.sv
source/correlation_normalizer.sv
source/template_correlator.sv
testbench/correlator_asserts.sv
testbench/tb_template_correlator.sv

//--- Makefile
SIM      := verilator
TOP      := tb_template_correlator
FLIST    := flist.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD)
LOG      := sim.log
FAIL_MSG := CHECKS FAILED
PASS_MSG := ALL CHECKS PASSED

BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FLIST))
DATA     := templates.hex norms.hex

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
